/* rtl/gnode_params.svh */
// ================================================
// Ring node constants
// Packet geometry, local bus widths and the host
// register map shared by the whole tile
// ================================================

`ifndef GNODE_PARAMS_SVH
`define GNODE_PARAMS_SVH

// Ring word width
`define GNODE_DATA_W        16
// One header word plus four payload words
`define GNODE_BFFR_SIZE     5
// Enough bits to index a packet image
`define GNODE_IDX_W         3
// Node id and header tag widths
`define GNODE_ID_W          4
`define GNODE_TAG_W         8

// Local bus geometry
`define LB_DATA_W           32
`define LB_ADDR_W           8

// Host register map
`define REG_CNTRL           8'h00
`define REG_STATUS          8'h01
`define REG_NODE_ID         8'h02
// Transmit image, GNODE_BFFR_SIZE words from here
`define REG_TX_BASE         8'h10
// Receive image, GNODE_BFFR_SIZE words from here
`define REG_RX_BASE         8'h20

// Read value for holes in the map
`define LB_UNMAPPED         32'hdead_babe

// CNTRL strobe bits
`define CNTRL_LAUNCH_BIT    0
`define CNTRL_RELEASE_BIT   1

`endif

/* rtl/gnode_pkg.sv */
// ================================================
// Ring node types
// Framing enum, header layout, ring word and the
// whole-packet image passed between tile blocks
// ================================================

`default_nettype none

`include "gnode_params.svh"

package gnode_pkg;

  // Framing of each word on a ring stream
  // IDLE means nothing is offered this cycle
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    SOP  = 2'd1,
    DATA = 2'd2,
    EOP  = 2'd3
  } gnode_cmd_t;

  // Header word, always the first word of a packet
  typedef struct packed {
    logic [`GNODE_ID_W-1:0]  dst;
    logic [`GNODE_ID_W-1:0]  src;
    logic [`GNODE_TAG_W-1:0] tag;
  } gnode_hdr_t;

  // One ring word
  // Header view on the SOP word, raw payload otherwise
  typedef union packed {
    gnode_hdr_t                hdr;
    logic [`GNODE_DATA_W-1:0]  data;
  } gnode_word_u;

  // Unit moved on every ring stream, 18 bits
  typedef struct packed {
    gnode_cmd_t  cmd;
    gnode_word_u word;
  } gnode_flit_t;

  // Whole packet image
  // Index 0 holds the header, the rest is payload
  typedef gnode_word_u [`GNODE_BFFR_SIZE-1:0] gnode_job_t;

endpackage

`default_nettype wire

/* rtl/gnode_hst_acc.sv */
// ================================================
// Host access block
// Local bus register file with transmit and receive
// packet images, launch control and sticky status
// ================================================

`timescale 1ns/100ps
`default_nettype none

`include "gnode_params.svh"

module gnode_hst_acc
  import gnode_pkg::*;
#(
  parameter int unsigned NODE_ID = 0
)
(
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     lb_wr_en,
  input  wire                     lb_rd_en,
  input  wire [`LB_ADDR_W-1:0]    lb_addr,
  input  wire [`LB_DATA_W-1:0]    lb_wr_data,
  output logic                    lb_wr_valid,
  output logic                    lb_rd_valid,
  output logic [`LB_DATA_W-1:0]   lb_rd_data,
  input  wire                     node_en,
  input  wire                     rx_job_valid,
  input  wire gnode_job_t         rx_job,
  output logic                    rx_busy,
  output logic                    tx_valid,
  output gnode_job_t              tx_job,
  input  wire                     tx_taken,
  input  wire                     tx_done,
  input  wire                     egr_ready,
  input  wire                     ingr_ready
);

  // Own id, trimmed to the header field
  localparam logic [`GNODE_ID_W-1:0] MY_ID = NODE_ID[`GNODE_ID_W-1:0];

  gnode_job_t                 tx_buf;
  gnode_job_t                 rx_buf;
  logic                       tx_pend;
  logic                       job_done;
  logic [`LB_ADDR_W-1:0]      tx_off;
  logic [`LB_ADDR_W-1:0]      rx_off;
  logic [`GNODE_IDX_W-1:0]    tx_idx;
  logic [`GNODE_IDX_W-1:0]    rx_idx;
  logic                       tx_hit;
  logic                       rx_hit;
  logic                       cntrl_wr;
  logic                       status_rd;
  logic                       launch;
  logic                       rx_release;
  logic [`LB_DATA_W-1:0]      rd_mux;

  // Buffer window decode
  // Below-base addresses wrap to large offsets and miss
  assign tx_off = lb_addr - `REG_TX_BASE;
  assign rx_off = lb_addr - `REG_RX_BASE;
  assign tx_hit = (tx_off < `GNODE_BFFR_SIZE);
  assign rx_hit = (rx_off < `GNODE_BFFR_SIZE);
  assign tx_idx = tx_off[`GNODE_IDX_W-1:0];
  assign rx_idx = rx_off[`GNODE_IDX_W-1:0];

  // Control strobes
  assign cntrl_wr   = lb_wr_en && (lb_addr == `REG_CNTRL);
  assign status_rd  = lb_rd_en && (lb_addr == `REG_STATUS);
  // Launch only when enabled and nothing still in flight
  assign launch     = cntrl_wr && lb_wr_data[`CNTRL_LAUNCH_BIT] && node_en && !tx_pend;
  assign rx_release = cntrl_wr && lb_wr_data[`CNTRL_RELEASE_BIT];

  // Transmit image as seen by egress
  always_comb
  begin
    tx_job = tx_buf;
    // Source is always this node
    tx_job[0].hdr.src = MY_ID;
  end

  // Read data select
  always_comb
  begin
    rd_mux = `LB_UNMAPPED;
    if (tx_hit)
    begin
      rd_mux = {{(`LB_DATA_W-`GNODE_DATA_W){1'b0}}, tx_buf[tx_idx].data};
    end
    else if (rx_hit)
    begin
      rd_mux = {{(`LB_DATA_W-`GNODE_DATA_W){1'b0}}, rx_buf[rx_idx].data};
    end
    else
    begin
      case (lb_addr)
        // Strobe bits, nothing to read back
        `REG_CNTRL:   rd_mux = '0;
        `REG_STATUS:  rd_mux = {{(`LB_DATA_W-5){1'b0}},
                                egr_ready, ingr_ready, job_done, rx_busy, tx_pend};
        `REG_NODE_ID: rd_mux = {{(`LB_DATA_W-`GNODE_ID_W){1'b0}}, MY_ID};
        default:      rd_mux = `LB_UNMAPPED;
      endcase
    end
  end

  // Bus handshake and control state
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      lb_wr_valid <= 1'b0;
      lb_rd_valid <= 1'b0;
      tx_valid    <= 1'b0;
      tx_pend     <= 1'b0;
      rx_busy     <= 1'b0;
      job_done    <= 1'b0;
    end
    else
    begin
      // Single cycle acknowledge
      lb_wr_valid <= lb_wr_en;
      lb_rd_valid <= lb_rd_en;
      // Request to egress, dropped once it is taken
      if (launch)
        tx_valid <= 1'b1;
      else if (tx_taken)
        tx_valid <= 1'b0;
      // Pending until the EOP has left the tile
      if (launch)
        tx_pend <= 1'b1;
      else if (tx_done)
        tx_pend <= 1'b0;
      // Receive image owned by host until released
      if (rx_job_valid)
        rx_busy <= 1'b1;
      else if (rx_release)
        rx_busy <= 1'b0;
      // Sticky done, a completion in the read cycle survives
      job_done <= tx_done | (job_done & ~status_rd);
    end
  end

  // Packet images and read data
  always_ff @(posedge clk)
  begin
    if (lb_wr_en && tx_hit)
      tx_buf[tx_idx].data <= lb_wr_data[`GNODE_DATA_W-1:0];
    if (rx_job_valid)
      rx_buf <= rx_job;
    if (lb_rd_en)
      lb_rd_data <= rd_mux;
  end

endmodule

`default_nettype wire

/* rtl/gnode_ingr.sv */
// ================================================
// Ingress parser
// Collects a whole packet, then hands it to the host
// or to the egress arbiter for forwarding
// ================================================

`timescale 1ns/100ps
`default_nettype none

`include "gnode_params.svh"

module gnode_ingr
  import gnode_pkg::*;
#(
  parameter int unsigned NODE_ID = 0
)
(
  input  wire               clk,
  input  wire               rst_n,
  input  wire               node_en,
  input  wire gnode_flit_t  ingr_flit,
  output logic              ingr_ready,
  input  wire               rx_busy,
  output logic              rx_job_valid,
  output gnode_job_t        rx_job,
  output logic              fwd_valid,
  output gnode_job_t        fwd_job,
  input  wire               fwd_taken
);

  localparam logic [`GNODE_ID_W-1:0] MY_ID = NODE_ID[`GNODE_ID_W-1:0];

  gnode_job_t                 img;
  logic [`GNODE_IDX_W-1:0]    widx;
  logic                       full;
  logic                       xfer;
  logic                       is_local;

  // Accept words only while collecting
  assign ingr_ready = ~full;
  assign xfer       = ingr_ready && (ingr_flit.cmd != IDLE);

  // Delivery decision on the held header
  // A disabled node forwards everything
  assign is_local   = node_en && (img[0].hdr.dst == MY_ID);

  // Host gets it only when its buffer is free
  assign rx_job_valid = full && is_local && !rx_busy;
  assign fwd_valid    = full && !is_local;

  // Same image offered to both sides
  assign rx_job  = img;
  assign fwd_job = img;

  // Word index and hold flag
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full <= 1'b0;
      widx <= '0;
    end
    else if (xfer)
    begin
      if (ingr_flit.cmd == SOP)
      begin
        // Header lands in slot 0
        widx <= `GNODE_IDX_W'(1);
      end
      else if (ingr_flit.cmd == EOP)
      begin
        widx <= '0;
        full <= 1'b1;
      end
      else
      begin
        widx <= widx + 1'b1;
      end
    end
    else if (rx_job_valid || fwd_taken)
    begin
      // Image handed off, open for the next packet
      full <= 1'b0;
    end
  end

  // Packet image
  always_ff @(posedge clk)
  begin
    if (xfer)
    begin
      if (ingr_flit.cmd == SOP)
        img[0] <= ingr_flit.word;
      else if (widx < `GNODE_BFFR_SIZE)
        img[widx] <= ingr_flit.word;
    end
  end

endmodule

`default_nettype wire

/* rtl/gnode_egr.sv */
// ================================================
// Egress arbiter
// Picks a forwarded or local packet, forwarded first,
// and sends it whole with SOP/DATA/EOP framing
// ================================================

`timescale 1ns/100ps
`default_nettype none

`include "gnode_params.svh"

module gnode_egr
  import gnode_pkg::*;
(
  input  wire               clk,
  input  wire               rst_n,
  input  wire               fwd_valid,
  input  wire gnode_job_t   fwd_job,
  output logic              fwd_taken,
  input  wire               tx_valid,
  input  wire gnode_job_t   tx_job,
  output logic              tx_taken,
  output logic              tx_done,
  output gnode_flit_t       egr_flit,
  input  wire               egr_ready
);

  localparam int unsigned LAST = `GNODE_BFFR_SIZE - 1;

  gnode_job_t                 img;
  logic [`GNODE_IDX_W-1:0]    idx;
  logic                       busy;
  logic                       from_tx;
  logic                       xfer;
  logic                       at_last;

  // Selection only when idle, forwarded traffic wins
  assign fwd_taken = !busy && fwd_valid;
  assign tx_taken  = !busy && !fwd_valid && tx_valid;

  assign xfer    = busy && egr_ready;
  assign at_last = (idx == LAST);

  // Output word straight from held state
  // Stays put while egr_ready is low
  always_comb
  begin
    egr_flit.word = busy ? img[idx] : '0;
    if (!busy)
      egr_flit.cmd = IDLE;
    else if (idx == '0)
      egr_flit.cmd = SOP;
    else if (at_last)
      egr_flit.cmd = EOP;
    else
      egr_flit.cmd = DATA;
  end

  // Send sequencer
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      idx     <= '0;
      from_tx <= 1'b0;
      tx_done <= 1'b0;
    end
    else
    begin
      // Done one cycle after the local EOP moves
      tx_done <= xfer && at_last && from_tx;
      if (!busy)
      begin
        if (fwd_taken || tx_taken)
        begin
          busy    <= 1'b1;
          idx     <= '0;
          from_tx <= tx_taken;
        end
      end
      else if (xfer)
      begin
        if (at_last)
        begin
          busy <= 1'b0;
          idx  <= '0;
        end
        else
        begin
          idx <= idx + 1'b1;
        end
      end
    end
  end

  // Latched packet image
  always_ff @(posedge clk)
  begin
    if (fwd_taken)
      img <= fwd_job;
    else if (tx_taken)
      img <= tx_job;
  end

endmodule

`default_nettype wire

/* rtl/gnode_host_tile.sv */
// ================================================
// Host tile top
// Host access, ingress parser and egress arbiter
// ================================================

`timescale 1ns/100ps
`default_nettype none

`include "gnode_params.svh"

module gnode_host_tile
  import gnode_pkg::*;
#(
  parameter int unsigned NODE_ID = 0
)
(
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     lb_wr_en,
  input  wire                     lb_rd_en,
  input  wire [`LB_ADDR_W-1:0]    lb_addr,
  input  wire [`LB_DATA_W-1:0]    lb_wr_data,
  output logic                    lb_wr_valid,
  output logic                    lb_rd_valid,
  output logic [`LB_DATA_W-1:0]   lb_rd_data,
  input  wire                     node_en,
  input  wire gnode_flit_t        ingr_flit,
  output logic                    ingr_ready,
  output gnode_flit_t             egr_flit,
  input  wire                     egr_ready
);

  // Ingress to host
  logic        rx_job_valid;
  gnode_job_t  rx_job;
  logic        rx_busy;
  // Ingress to egress
  logic        fwd_valid;
  gnode_job_t  fwd_job;
  logic        fwd_taken;
  // Host to egress
  logic        tx_valid;
  gnode_job_t  tx_job;
  logic        tx_taken;
  logic        tx_done;

  gnode_hst_acc #(
    .NODE_ID      (NODE_ID)
  ) hst_acc_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .lb_wr_en     (lb_wr_en),
    .lb_rd_en     (lb_rd_en),
    .lb_addr      (lb_addr),
    .lb_wr_data   (lb_wr_data),
    .lb_wr_valid  (lb_wr_valid),
    .lb_rd_valid  (lb_rd_valid),
    .lb_rd_data   (lb_rd_data),
    .node_en      (node_en),
    .rx_job_valid (rx_job_valid),
    .rx_job       (rx_job),
    .rx_busy      (rx_busy),
    .tx_valid     (tx_valid),
    .tx_job       (tx_job),
    .tx_taken     (tx_taken),
    .tx_done      (tx_done),
    .egr_ready    (egr_ready),
    .ingr_ready   (ingr_ready)
  );

  gnode_ingr #(
    .NODE_ID      (NODE_ID)
  ) ingr_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .node_en      (node_en),
    .ingr_flit    (ingr_flit),
    .ingr_ready   (ingr_ready),
    .rx_busy      (rx_busy),
    .rx_job_valid (rx_job_valid),
    .rx_job       (rx_job),
    .fwd_valid    (fwd_valid),
    .fwd_job      (fwd_job),
    .fwd_taken    (fwd_taken)
  );

  gnode_egr egr_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .fwd_valid    (fwd_valid),
    .fwd_job      (fwd_job),
    .fwd_taken    (fwd_taken),
    .tx_valid     (tx_valid),
    .tx_job       (tx_job),
    .tx_taken     (tx_taken),
    .tx_done      (tx_done),
    .egr_flit     (egr_flit),
    .egr_ready    (egr_ready)
  );

endmodule

`default_nettype wire

/* verif/gnode_tile_properties.sv */
// ==================================================
// Host tile properties
// Local bus acknowledge timing, egress hold under
// back-pressure and packet framing on egress
// ==================================================

`timescale 1ns/100ps
`default_nettype none

`include "gnode_params.svh"

module gnode_tile_properties
  import gnode_pkg::*;
(
  input wire              clk,
  input wire              rst_n,
  input wire              lb_wr_en,
  input wire              lb_rd_en,
  input wire              lb_wr_valid,
  input wire              lb_rd_valid,
  input wire gnode_flit_t egr_flit,
  input wire              egr_ready
);

  // Running total of assertion failures
  int unsigned              fail_count = 0;
  logic [`GNODE_IDX_W-1:0]  words_left;
  logic                     egr_xfer;

  assign egr_xfer = (egr_flit.cmd != IDLE) && egr_ready;

  // Words still owed by the packet on the wire
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      words_left <= '0;
    else if (egr_xfer)
    begin
      if (egr_flit.cmd == SOP)
        words_left <= `GNODE_IDX_W'(`GNODE_BFFR_SIZE - 1);
      else
        words_left <= words_left - 1'b1;
    end
  end

  wr_ack_timing: assert property (
    @(posedge clk) disable iff (!rst_n) lb_wr_valid == $past(lb_wr_en))
  else
  begin
    fail_count++;
    $error("lb_wr_valid did not follow lb_wr_en by one cycle");
  end

  rd_ack_timing: assert property (
    @(posedge clk) disable iff (!rst_n) lb_rd_valid == $past(lb_rd_en))
  else
  begin
    fail_count++;
    $error("lb_rd_valid did not follow lb_rd_en by one cycle");
  end

  // Offered word frozen until taken
  egr_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (egr_flit.cmd != IDLE && !egr_ready) |=> $stable(egr_flit))
  else
  begin
    fail_count++;
    $error("egr_flit changed while egr_ready was low");
  end

  // New packet only once the last one is complete
  sop_spacing: assert property (
    @(posedge clk) disable iff (!rst_n)
    egr_xfer |-> ((egr_flit.cmd == SOP) == (words_left == '0)))
  else
  begin
    fail_count++;
    $error("SOP not separated by a whole packet of words");
  end

  eop_position: assert property (
    @(posedge clk) disable iff (!rst_n)
    (egr_xfer && egr_flit.cmd == EOP) |-> (words_left == 1))
  else
  begin
    fail_count++;
    $error("EOP not on the last word of a packet");
  end

endmodule

bind gnode_host_tile gnode_tile_properties props_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .lb_wr_en     (lb_wr_en),
  .lb_rd_en     (lb_rd_en),
  .lb_wr_valid  (lb_wr_valid),
  .lb_rd_valid  (lb_rd_valid),
  .egr_flit     (egr_flit),
  .egr_ready    (egr_ready)
);

`default_nettype wire

/* verif/gnode_tile_tb.sv */
// ==================================================
// Host tile testbench
// Table of local bus and ring steps, with a packet
// driver on ingress and a word monitor on egress
// ==================================================

`timescale 1ns/100ps
`default_nettype none

`include "gnode_params.svh"

module gnode_tile_tb
  import gnode_pkg::*;
();

  localparam int unsigned TILE_ID     = 3;
  localparam int unsigned WAIT_MAX    = 200;
  localparam int unsigned NUM_STEPS   = 42;
  localparam int unsigned WATCHDOG_NS = 1_000_000;

  // Step kinds
  typedef enum logic [3:0] {
    OP_WR, OP_RD, OP_LOAD, OP_TXCHK, OP_RXCHK, OP_INJ,
    OP_EGR, OP_QUIET, OP_READY, OP_NODE_EN
  } op_t;

  // One table row
  // addr is a packet dst for LOAD and INJ, value a tag, mode or flag
  typedef struct packed {
    op_t          op;
    logic [7:0]   addr;
    logic [31:0]  value;
    logic [31:0]  mask;
    logic [2:0]   slot;
  } step_t;

  step_t steps [NUM_STEPS] = '{
    // Reset state and register map
    '{OP_QUIET,   8'h00,         32'd4,          32'h0,          3'd0},
    '{OP_RD,      `REG_STATUS,   32'h0000_0018,  32'h0000_001f,  3'd0},
    '{OP_RD,      `REG_NODE_ID,  32'd3,          32'hffff_ffff,  3'd0},
    '{OP_RD,      8'h7f,         `LB_UNMAPPED,   32'hffff_ffff,  3'd0},
    '{OP_RD,      8'h15,         `LB_UNMAPPED,   32'hffff_ffff,  3'd0},
    // Transmit image readback
    '{OP_LOAD,    8'h09,         32'h5a,         32'h0,          3'd0},
    '{OP_TXCHK,   `REG_TX_BASE,  32'h0,          32'h0,          3'd0},
    // Launch under random egress stalls, then sticky done
    '{OP_READY,   8'h00,         32'd2,          32'h0,          3'd0},
    '{OP_WR,      `REG_CNTRL,    32'h1,          32'h0,          3'd0},
    '{OP_EGR,     8'h00,         32'h1,          32'h0,          3'd0},
    '{OP_RD,      `REG_STATUS,   32'h4,          32'h7,          3'd0},
    '{OP_RD,      `REG_STATUS,   32'h0,          32'h7,          3'd0},
    // Delivery to host, second packet held until release
    '{OP_READY,   8'h00,         32'd1,          32'h0,          3'd0},
    '{OP_INJ,     8'h03,         32'h11,         32'h0,          3'd1},
    '{OP_RXCHK,   `REG_RX_BASE,  32'h0,          32'h0,          3'd1},
    '{OP_RD,      `REG_STATUS,   32'h0a,         32'h0a,         3'd0},
    '{OP_INJ,     8'h03,         32'h22,         32'h0,          3'd2},
    '{OP_QUIET,   8'h00,         32'd8,          32'h0,          3'd0},
    '{OP_RD,      `REG_STATUS,   32'h02,         32'h0a,         3'd0},
    '{OP_RXCHK,   `REG_RX_BASE,  32'h0,          32'h0,          3'd1},
    '{OP_WR,      `REG_CNTRL,    32'h2,          32'h0,          3'd0},
    '{OP_RXCHK,   `REG_RX_BASE,  32'h0,          32'h0,          3'd2},
    '{OP_WR,      `REG_CNTRL,    32'h2,          32'h0,          3'd0},
    '{OP_RD,      `REG_STATUS,   32'h08,         32'h0a,         3'd0},
    // Forwarding, and priority over a pending local send
    '{OP_INJ,     8'h05,         32'h33,         32'h0,          3'd3},
    '{OP_EGR,     8'h00,         32'h0,          32'h0,          3'd3},
    '{OP_READY,   8'h00,         32'd0,          32'h0,          3'd0},
    '{OP_INJ,     8'h05,         32'h44,         32'h0,          3'd4},
    '{OP_INJ,     8'h06,         32'h55,         32'h0,          3'd5},
    '{OP_LOAD,    8'h0c,         32'h66,         32'h0,          3'd6},
    '{OP_WR,      `REG_CNTRL,    32'h1,          32'h0,          3'd0},
    '{OP_READY,   8'h00,         32'd2,          32'h0,          3'd0},
    '{OP_EGR,     8'h00,         32'h0,          32'h0,          3'd4},
    '{OP_EGR,     8'h00,         32'h0,          32'h0,          3'd5},
    '{OP_EGR,     8'h00,         32'h1,          32'h0,          3'd6},
    // Disabled node forwards everything, launch ignored
    '{OP_READY,   8'h00,         32'd1,          32'h0,          3'd0},
    '{OP_NODE_EN, 8'h00,         32'd0,          32'h0,          3'd0},
    '{OP_INJ,     8'h03,         32'h77,         32'h0,          3'd7},
    '{OP_EGR,     8'h00,         32'h0,          32'h0,          3'd7},
    '{OP_WR,      `REG_CNTRL,    32'h1,          32'h0,          3'd0},
    '{OP_RD,      `REG_STATUS,   32'h0,          32'h3,          3'd0},
    '{OP_QUIET,   8'h00,         32'd8,          32'h0,          3'd0}
  };

  logic                     clk;
  logic                     rst_n;
  logic                     lb_wr_en;
  logic                     lb_rd_en;
  logic [`LB_ADDR_W-1:0]    lb_addr;
  logic [`LB_DATA_W-1:0]    lb_wr_data;
  logic                     lb_wr_valid;
  logic                     lb_rd_valid;
  logic [`LB_DATA_W-1:0]    lb_rd_data;
  logic                     node_en;
  gnode_flit_t              ingr_flit;
  logic                     ingr_ready;
  gnode_flit_t              egr_flit;
  logic                     egr_ready;

  // Packet images by slot, header in word 0
  logic [`GNODE_DATA_W-1:0] pkt_mem [8][`GNODE_BFFR_SIZE];
  // Words seen leaving the tile
  gnode_flit_t              egr_q [$];
  // 0 held low, 1 always high, 2 random gaps
  logic [1:0]               ready_mode;
  int unsigned              errors;
  int unsigned              checks;

  gnode_host_tile #(
    .NODE_ID      (TILE_ID)
  ) dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .lb_wr_en     (lb_wr_en),
    .lb_rd_en     (lb_rd_en),
    .lb_addr      (lb_addr),
    .lb_wr_data   (lb_wr_data),
    .lb_wr_valid  (lb_wr_valid),
    .lb_rd_valid  (lb_rd_valid),
    .lb_rd_data   (lb_rd_data),
    .node_en      (node_en),
    .ingr_flit    (ingr_flit),
    .ingr_ready   (ingr_ready),
    .egr_flit     (egr_flit),
    .egr_ready    (egr_ready)
  );

  always #20 clk = ~clk;

  // Egress back-pressure
  always @(negedge clk)
  begin
    if (ready_mode == 2'd2)
      egr_ready = ($urandom % 3) != 0;
    else
      egr_ready = (ready_mode == 2'd1);
  end

  // A word moves when offered and ready at the edge
  always @(posedge clk)
  begin
    if (rst_n && egr_flit.cmd != IDLE && egr_ready)
      egr_q.push_back(egr_flit);
  end

  // Framing by position in the packet
  function automatic gnode_cmd_t word_cmd(input int i);
    if (i == 0)
      return SOP;
    else if (i == `GNODE_BFFR_SIZE - 1)
      return EOP;
    else
      return DATA;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("mismatch %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    int unsigned n;
    @(negedge clk);
    lb_wr_en   = 1'b1;
    lb_addr    = addr;
    lb_wr_data = data;
    @(negedge clk);
    lb_wr_en = 1'b0;
    n = 1;
    while (!lb_wr_valid && n < WAIT_MAX)
    begin
      @(negedge clk);
      n++;
    end
    checks++;
    assert (n == 1)
    else
    begin
      $display("write to %h was not acknowledged one cycle after its enable", addr);
      errors++;
    end
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    int unsigned n;
    @(negedge clk);
    lb_rd_en = 1'b1;
    lb_addr  = addr;
    @(negedge clk);
    lb_rd_en = 1'b0;
    n = 1;
    while (!lb_rd_valid && n < WAIT_MAX)
    begin
      @(negedge clk);
      n++;
    end
    data = lb_rd_data;
    checks++;
    assert (n == 1)
    else
    begin
      $display("read of %h returned no data one cycle after its enable", addr);
      errors++;
    end
  endtask

  // Header from its fields, payload random
  task automatic build_pkt(input int slot, input logic [3:0] dst, input logic [3:0] src,
                           input logic [7:0] tag);
    gnode_hdr_t hdr;
    hdr.dst = dst;
    hdr.src = src;
    hdr.tag = tag;
    pkt_mem[slot][0] = hdr;
    for (int i = 1; i < `GNODE_BFFR_SIZE; i++)
      pkt_mem[slot][i] = `GNODE_DATA_W'($urandom);
  endtask

  // Fill the transmit image, src deliberately foreign
  task automatic load_tx(input int slot, input logic [3:0] dst, input logic [7:0] tag);
    build_pkt(slot, dst, 4'ha, tag);
    for (int i = 0; i < `GNODE_BFFR_SIZE; i++)
      bus_write(`REG_TX_BASE + 8'(i), 32'(pkt_mem[slot][i]));
  endtask

  task automatic check_buf(input logic [7:0] base, input int slot);
    logic [31:0] rd;
    for (int i = 0; i < `GNODE_BFFR_SIZE; i++)
    begin
      bus_read(base + 8'(i), rd);
      check_val($sformatf("lb_rd_data @ %h", base + 8'(i)), rd, 32'(pkt_mem[slot][i]));
    end
  endtask

  // A word moves on the rising edge after ready is seen high
  task automatic inject_pkt(input int slot);
    int unsigned n;
    for (int i = 0; i < `GNODE_BFFR_SIZE; i++)
    begin
      @(negedge clk);
      ingr_flit.cmd       = word_cmd(i);
      ingr_flit.word.data = pkt_mem[slot][i];
      n = 0;
      while (!ingr_ready && n < WAIT_MAX)
      begin
        @(negedge clk);
        n++;
      end
      checks++;
      assert (n < WAIT_MAX)
      else
      begin
        $display("ingress never accepted word %0d of slot %0d", i, slot);
        errors++;
      end
    end
    @(negedge clk);
    ingr_flit = '0;
    // Complete packet closes the input until it is handed off
    check_val("ingr_ready", 32'(ingr_ready), 32'd0);
  endtask

  task automatic expect_pkt(input int slot, input bit own_src);
    int unsigned                n;
    gnode_flit_t                f;
    gnode_hdr_t                 hdr;
    logic [`GNODE_DATA_W-1:0]   exp_word;
    n = 0;
    while (egr_q.size() < `GNODE_BFFR_SIZE && n < WAIT_MAX)
    begin
      @(negedge clk);
      n++;
    end
    checks++;
    assert (egr_q.size() >= `GNODE_BFFR_SIZE)
    else
    begin
      $display("egress packet for slot %0d never completed", slot);
      errors++;
    end
    if (egr_q.size() >= `GNODE_BFFR_SIZE)
    begin
      for (int i = 0; i < `GNODE_BFFR_SIZE; i++)
      begin
        f        = egr_q.pop_front();
        exp_word = pkt_mem[slot][i];
        // Local sends carry this node as src
        if (i == 0 && own_src)
        begin
          hdr      = exp_word;
          hdr.src  = 4'(TILE_ID);
          exp_word = hdr;
        end
        check_val($sformatf("egr_flit.cmd word %0d", i), 32'(f.cmd), 32'(word_cmd(i)));
        check_val($sformatf("egr_flit.word word %0d", i), 32'(f.word.data), 32'(exp_word));
      end
    end
  endtask

  // Nothing may leave the tile over the window
  task automatic quiet(input int unsigned cycles);
    for (int unsigned i = 0; i < cycles; i++)
    begin
      @(negedge clk);
      check_val("egr_flit.cmd", 32'(egr_flit.cmd), 32'(IDLE));
    end
    check_val("egress word count", egr_q.size(), 32'd0);
  endtask

  initial
  begin
    step_t        st;
    int unsigned  errs_before;
    int unsigned  failed_steps;
    int unsigned  prop_fails;
    logic [31:0]  rd_data;
    void'($urandom(13));
    clk          = 1'b0;
    rst_n        = 1'b0;
    lb_wr_en     = 1'b0;
    lb_rd_en     = 1'b0;
    lb_addr      = '0;
    lb_wr_data   = '0;
    node_en      = 1'b1;
    ingr_flit    = '0;
    egr_ready    = 1'b1;
    ready_mode   = 2'd1;
    errors       = 0;
    checks       = 0;
    failed_steps = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < NUM_STEPS; i++)
    begin
      st          = steps[i];
      errs_before = errors;
      case (st.op)
        OP_WR:    bus_write(st.addr, st.value);
        OP_RD:
        begin
          bus_read(st.addr, rd_data);
          check_val($sformatf("lb_rd_data @ %h", st.addr), rd_data & st.mask,
                    st.value & st.mask);
        end
        OP_LOAD:  load_tx(st.slot, st.addr[3:0], st.value[7:0]);
        OP_TXCHK: check_buf(st.addr, st.slot);
        OP_RXCHK: check_buf(st.addr, st.slot);
        OP_INJ:
        begin
          build_pkt(st.slot, st.addr[3:0], 4'h1, st.value[7:0]);
          inject_pkt(st.slot);
        end
        OP_EGR:   expect_pkt(st.slot, st.value[0]);
        OP_QUIET: quiet(st.value);
        // Mode changes off the drive edge
        OP_READY:
        begin
          @(posedge clk);
          ready_mode = st.value[1:0];
        end
        OP_NODE_EN:
        begin
          @(negedge clk);
          node_en = st.value[0];
        end
        default:  ;
      endcase
      if (errors == errs_before)
      begin
        $display("step %0d %s ok", i, st.op.name());
      end
      else
      begin
        failed_steps++;
        $display("step %0d %s FAIL", i, st.op.name());
      end
    end

    prop_fails = dut_i.props_i.fail_count;
    $display("steps %0d failed %0d checks %0d errors %0d assertion failures %0d",
             NUM_STEPS, failed_steps, checks, errors, prop_fails);
    if (errors == 0 && failed_steps == 0 && prop_fails == 0)
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

  // Last resort against a stuck run
  initial
  begin
    #(WATCHDOG_NS);
    $display("run exceeded its time limit");
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+rtl
rtl/gnode_pkg.sv
rtl/gnode_hst_acc.sv
rtl/gnode_ingr.sv
rtl/gnode_egr.sv
rtl/gnode_host_tile.sv
verif/gnode_tile_properties.sv
verif/gnode_tile_tb.sv
